//--- design/synth_settings.svh
`ifndef SYNTH_SETTINGS_SVH
`define SYNTH_SETTINGS_SVH

// ----------------------------------------------------------
// MIDI serial input
// ----------------------------------------------------------

// iMCLK cycles per MIDI bit
// Real hardware would use the 31250 baud rate here
`define SYNTH_CLKS_PER_BIT 32

// MIDI channel of voice 0
// Voice 1 listens on the next channel up
`define SYNTH_BASE_CHANNEL 0

// Channel volume loaded at reset
`define SYNTH_DEFAULT_VOLUME 127

// ----------------------------------------------------------
// I2S output
// ----------------------------------------------------------

// iMCLK cycles per BCLK period
// 64 BCLK per frame gives 256 iMCLK per frame
`define SYNTH_BCLK_DIV 4

`endif

//--- design/synthPkg.sv
package synthPkg;

	// ----------------------------------------------------------
	// Audio sample
	// ----------------------------------------------------------

	// Signed 16-bit PCM word
	typedef logic signed [15:0] sampleT;

	// ----------------------------------------------------------
	// MIDI message
	// ----------------------------------------------------------

	// Channel message classes the decoder acts on
	typedef enum logic [1:0]
	{
		kindNoteOff    = 2'd0,
		kindNoteOn     = 2'd1,
		kindCtrlChange = 2'd2,
		kindOther      = 2'd3
	} msgKindE;

	// Note on and note off data pair
	typedef struct packed
	{
		logic [7:0] key;
		logic [7:0] velocity;
	} noteViewS;

	// Control change data pair
	typedef struct packed
	{
		logic [7:0] number;
		logic [7:0] value;
	} ctrlViewS;

	// Same two data bytes, read by message kind
	typedef union packed
	{
		noteViewS note;
		ctrlViewS ctrl;
	} midiMsgU;

endpackage

//--- design/midiByteRx.sv
`timescale 1ns/100ps
`include "synth_settings.svh"

module midiByteRx
(
	input  logic       iMCLK,
	input  logic       reset,
	input  logic       serialIn,
	output logic [7:0] rxByte,
	output logic       byteValid
);

	// serialIn is the inverted MIDI line and idles low
	localparam int ClksPerBit = `SYNTH_CLKS_PER_BIT;
	localparam int CntW = $clog2(ClksPerBit);
	localparam logic [CntW-1:0] HalfBit = CntW'(ClksPerBit / 2 - 1);
	localparam logic [CntW-1:0] FullBit = CntW'(ClksPerBit - 1);

	// FSM encoding
	localparam logic [1:0] StIdle  = 2'd0;
	localparam logic [1:0] StStart = 2'd1;
	localparam logic [1:0] StData  = 2'd2;
	localparam logic [1:0] StStop  = 2'd3;

	logic [1:0]      syncReg;
	logic            rxBit;
	logic [1:0]      state;
	logic [CntW-1:0] clkCnt;
	logic [2:0]      bitIdx;

	// ----------------------------------------------------------
	// Input inversion and synchronizer
	// ----------------------------------------------------------

	// Back to UART polarity, idle high and start bit low
	always_ff @(posedge iMCLK)
	begin
		if (reset)
			syncReg <= 2'b11;
		else
			syncReg <= {syncReg[0], ~serialIn};
	end

	assign rxBit = syncReg[1];

	// ----------------------------------------------------------
	// Bit timing FSM
	// ----------------------------------------------------------

	always_ff @(posedge iMCLK)
	begin
		if (reset)
		begin
			state     <= StIdle;
			clkCnt    <= '0;
			bitIdx    <= '0;
			byteValid <= 1'b0;
		end
		else
		begin
			byteValid <= 1'b0;
			case (state)
				StIdle:
				begin
					clkCnt <= '0;
					bitIdx <= '0;
					if (!rxBit)
						state <= StStart;
				end
				StStart:
				begin
					// Half a bit in, the start bit must still be low
					if (clkCnt == HalfBit)
					begin
						clkCnt <= '0;
						state  <= rxBit ? StIdle : StData;
					end
					else
						clkCnt <= clkCnt + 1'b1;
				end
				StData:
				begin
					if (clkCnt == FullBit)
					begin
						clkCnt <= '0;
						bitIdx <= bitIdx + 3'd1;
						if (bitIdx == 3'd7)
							state <= StStop;
					end
					else
						clkCnt <= clkCnt + 1'b1;
				end
				default:
				begin
					// Mid stop bit, a low level here is a framing error
					if (clkCnt == FullBit)
					begin
						byteValid <= rxBit;
						state     <= StIdle;
					end
					else
						clkCnt <= clkCnt + 1'b1;
				end
			endcase
		end
	end

	// LSB first, so shift in from the top
	always_ff @(posedge iMCLK)
	begin
		if (state == StData && clkCnt == FullBit)
			rxByte <= {rxBit, rxByte[7:1]};
	end

endmodule

//--- design/midiDecoder.sv
`timescale 1ns/100ps
`include "synth_settings.svh"

module midiDecoder
(
	input  logic       iMCLK,
	input  logic       reset,
	input  logic [7:0] rxByte,
	input  logic       byteValid,
	output logic       gate0,
	output logic       gate1,
	output logic [6:0] key0,
	output logic [6:0] key1,
	output logic [6:0] velocity0,
	output logic [6:0] velocity1,
	output logic [6:0] volume0,
	output logic [6:0] volume1
);

	localparam logic [3:0] BaseCh        = 4'(`SYNTH_BASE_CHANNEL);
	localparam logic [6:0] DefaultVolume = 7'(`SYNTH_DEFAULT_VOLUME);
	// Channel volume controller
	localparam logic [7:0] CcVolume      = 8'd7;

	// Bit 7 clear means no running status
	logic [7:0]        runStatus;
	logic              haveFirst;
	logic [7:0]        firstData;
	logic              twoData;
	logic              msgDone;
	synthPkg::midiMsgU msg;
	synthPkg::msgKindE kind;

	// Per voice state
	logic [1:0]        gateR;
	logic [6:0]        keyR [2];
	logic [6:0]        velR [2];
	logic [6:0]        volR [2];

	// ----------------------------------------------------------
	// Byte parser with running status
	// ----------------------------------------------------------

	// Program change and channel pressure carry one data byte
	assign twoData = (runStatus[6:5] != 2'b10);

	always_ff @(posedge iMCLK)
	begin
		if (reset)
		begin
			runStatus <= 8'h00;
			haveFirst <= 1'b0;
		end
		else if (byteValid)
		begin
			if (rxByte[7])
			begin
				// Real-time bytes may fall inside a message
				if (rxByte[7:3] != 5'b11111)
				begin
					runStatus <= (rxByte[7:4] == 4'hF) ? 8'h00 : rxByte;
					haveFirst <= 1'b0;
				end
			end
			else if (runStatus[7])
				haveFirst <= twoData && !haveFirst;
		end
	end

	always_ff @(posedge iMCLK)
	begin
		if (byteValid && !rxByte[7] && !haveFirst)
			firstData <= rxByte;
	end

	// Last data byte of a complete message
	assign msgDone = byteValid && !rxByte[7] && runStatus[7] && (!twoData || haveFirst);
	assign msg     = twoData ? {firstData, rxByte} : {rxByte, 8'h00};

	always_comb
	begin
		case (runStatus[7:4])
			4'h8:    kind = synthPkg::kindNoteOff;
			4'h9:    kind = synthPkg::kindNoteOn;
			4'hB:    kind = synthPkg::kindCtrlChange;
			default: kind = synthPkg::kindOther;
		endcase
	end

	// ----------------------------------------------------------
	// Voice state update
	// ----------------------------------------------------------

	always_ff @(posedge iMCLK)
	begin
		if (reset)
		begin
			gateR <= 2'b00;
			for (int v = 0; v < 2; v++)
			begin
				keyR[v] <= '0;
				velR[v] <= '0;
				volR[v] <= DefaultVolume;
			end
		end
		else if (msgDone)
		begin
			for (int v = 0; v < 2; v++)
			begin
				// Channels other than the two voices fall through
				if (runStatus[3:0] == BaseCh + 4'(v))
				begin
					case (kind)
						synthPkg::kindNoteOn:
						begin
							if (msg.note.velocity[6:0] != 7'd0)
							begin
								gateR[v] <= 1'b1;
								keyR[v]  <= msg.note.key[6:0];
								velR[v]  <= msg.note.velocity[6:0];
							end
							// velocity zero acts as note off
							else if (msg.note.key[6:0] == keyR[v])
								gateR[v] <= 1'b0;
						end
						synthPkg::kindNoteOff:
						begin
							if (msg.note.key[6:0] == keyR[v])
								gateR[v] <= 1'b0;
						end
						synthPkg::kindCtrlChange:
						begin
							if (msg.ctrl.number == CcVolume)
								volR[v] <= msg.ctrl.value[6:0];
						end
						default:
						begin
						end
					endcase
				end
			end
		end
	end

	assign gate0     = gateR[0];
	assign gate1     = gateR[1];
	assign key0      = keyR[0];
	assign key1      = keyR[1];
	assign velocity0 = velR[0];
	assign velocity1 = velR[1];
	assign volume0   = volR[0];
	assign volume1   = volR[1];

endmodule

//--- design/toneVoice.sv
`timescale 1ns/100ps

module toneVoice
(
	input  logic            iMCLK,
	input  logic            reset,
	input  logic            sampleReq,
	input  logic            gate,
	input  logic [6:0]      key,
	input  logic [6:0]      velocity,
	input  logic [6:0]      volume,
	output synthPkg::sampleT sample
);

	logic             gateD;
	logic             gateRise;
	logic             phase;
	logic [7:0]       frameCnt;
	logic [7:0]       halfPeriod;
	logic [13:0]      ampR;
	// State as seen this cycle, onset already applied
	logic             curPhase;
	logic [7:0]       curCnt;
	logic [13:0]      curAmp;
	synthPkg::sampleT ampS;

	// Higher key gives a shorter half period, 1 to 128 frames
	assign halfPeriod = 8'd128 - {1'b0, key};

	assign gateRise = gate & ~gateD;
	assign curPhase = gateRise | phase;
	assign curCnt   = gateRise ? 8'd0 : frameCnt;
	assign curAmp   = gateRise ? velocity * volume : ampR;
	assign ampS     = {2'b00, curAmp};

	// Amplitude held for the whole note
	always_ff @(posedge iMCLK)
	begin
		if (gateRise)
			ampR <= velocity * volume;
	end

	// ----------------------------------------------------------
	// Square wave per frame
	// ----------------------------------------------------------

	always_ff @(posedge iMCLK)
	begin
		if (reset)
		begin
			gateD    <= 1'b0;
			phase    <= 1'b0;
			frameCnt <= '0;
			sample   <= '0;
		end
		else
		begin
			gateD <= gate;
			if (sampleReq)
			begin
				if (!gate)
					sample <= '0;
				else
				begin
					sample <= curPhase ? ampS : -ampS;
					if (curCnt == halfPeriod - 8'd1)
					begin
						frameCnt <= '0;
						phase    <= ~curPhase;
					end
					else
					begin
						frameCnt <= curCnt + 8'd1;
						phase    <= curPhase;
					end
				end
			end
			else if (gateRise)
			begin
				// Onset starts on the positive half
				frameCnt <= '0;
				phase    <= 1'b1;
			end
		end
	end

endmodule

//--- design/voiceMixer.sv
`timescale 1ns/100ps

module voiceMixer
(
	input  logic             iMCLK,
	input  logic             reset,
	input  logic             sampleReq,
	input  synthPkg::sampleT sample0,
	input  synthPkg::sampleT sample1,
	output synthPkg::sampleT mix
);

	// Voice samples settle one cycle after the request
	logic reqD;

	// ----------------------------------------------------------
	// Mono sum
	// ----------------------------------------------------------

	// Each voice peaks at 127 * 127
	// two of them stay inside 16 bits
	always_ff @(posedge iMCLK)
	begin
		if (reset)
		begin
			reqD <= 1'b0;
			mix  <= '0;
		end
		else
		begin
			reqD <= sampleReq;
			if (reqD)
				mix <= sample0 + sample1;
		end
	end

endmodule

//--- design/i2sTransmitter.sv
`timescale 1ns/100ps
`include "synth_settings.svh"

module i2sTransmitter
(
	input  logic             iMCLK,
	input  logic             reset,
	input  synthPkg::sampleT mix,
	output logic             sampleReq,
	output logic             i2sBclk,
	output logic             i2sLrclk,
	output logic             i2sSdata
);

	localparam int BclkDiv = `SYNTH_BCLK_DIV;
	localparam int DivW = $clog2(BclkDiv);
	localparam logic [DivW-1:0] DivLast = DivW'(BclkDiv - 1);
	localparam logic [DivW-1:0] DivHalf = DivW'(BclkDiv / 2 - 1);

	logic [DivW-1:0]  divCnt;
	logic             bclkFall;
	// Bit position in the 64-bit frame, bit 5 selects the slot
	logic [5:0]       bitCnt;
	logic [5:0]       nextPos;
	synthPkg::sampleT holdReg;
	logic [15:0]      shiftReg;

	assign bclkFall = (divCnt == DivLast);
	assign nextPos  = bitCnt + 6'd1;

	// ----------------------------------------------------------
	// Clocks, frame strobe and serial data
	// ----------------------------------------------------------

	// Everything moves on the falling BCLK edge
	always_ff @(posedge iMCLK)
	begin
		if (reset)
		begin
			divCnt    <= '0;
			bitCnt    <= '0;
			sampleReq <= 1'b0;
			i2sBclk   <= 1'b0;
			i2sLrclk  <= 1'b0;
			i2sSdata  <= 1'b0;
			holdReg   <= '0;
			shiftReg  <= '0;
		end
		else
		begin
			// Pulse together with LRCLK going low
			sampleReq <= bclkFall && (nextPos == 6'd0);
			if (bclkFall)
			begin
				divCnt   <= '0;
				bitCnt   <= nextPos;
				i2sBclk  <= 1'b0;
				i2sLrclk <= nextPos[5];
				// Slot start sends the spent register, which is all zeros
				i2sSdata <= shiftReg[15];
				if (nextPos == 6'd0)
				begin
					// Left slot, previous frame's mix
					shiftReg <= mix;
					holdReg  <= mix;
				end
				else if (nextPos == 6'd32)
					shiftReg <= holdReg;
				else
					shiftReg <= {shiftReg[14:0], 1'b0};
			end
			else
			begin
				divCnt <= divCnt + 1'b1;
				// second half of the period is high
				if (divCnt == DivHalf)
					i2sBclk <= 1'b1;
			end
		end
	end

endmodule

//--- design/synthTop.sv
`timescale 1ns/100ps

module synthTop
(
	input  logic iMCLK,
	input  logic reset,
	input  logic midiIn,
	output logic i2sMclk,
	output logic i2sBclk,
	output logic i2sLrclk,
	output logic i2sSdata
);

	// Receiver to decoder
	logic [7:0]       rxByte;
	logic             byteValid;

	// Decoder to voices
	logic             gate0;
	logic             gate1;
	logic [6:0]       key0;
	logic [6:0]       key1;
	logic [6:0]       velocity0;
	logic [6:0]       velocity1;
	logic [6:0]       volume0;
	logic [6:0]       volume1;

	// Audio path
	logic             sampleReq;
	synthPkg::sampleT sample0;
	synthPkg::sampleT sample1;
	synthPkg::sampleT mix;

	// ----------------------------------------------------------
	// MIDI input
	// ----------------------------------------------------------

	midiByteRx rxInst
	(
		.iMCLK(iMCLK),
		.reset(reset),
		.serialIn(midiIn),
		.rxByte(rxByte),
		.byteValid(byteValid)
	);

	midiDecoder decoderInst
	(
		.iMCLK(iMCLK),
		.reset(reset),
		.rxByte(rxByte),
		.byteValid(byteValid),
		.gate0(gate0),
		.gate1(gate1),
		.key0(key0),
		.key1(key1),
		.velocity0(velocity0),
		.velocity1(velocity1),
		.volume0(volume0),
		.volume1(volume1)
	);

	// ----------------------------------------------------------
	// Voices and mix
	// ----------------------------------------------------------

	toneVoice voice0Inst
	(
		.iMCLK(iMCLK),
		.reset(reset),
		.sampleReq(sampleReq),
		.gate(gate0),
		.key(key0),
		.velocity(velocity0),
		.volume(volume0),
		.sample(sample0)
	);

	toneVoice voice1Inst
	(
		.iMCLK(iMCLK),
		.reset(reset),
		.sampleReq(sampleReq),
		.gate(gate1),
		.key(key1),
		.velocity(velocity1),
		.volume(volume1),
		.sample(sample1)
	);

	voiceMixer mixerInst
	(
		.iMCLK(iMCLK),
		.reset(reset),
		.sampleReq(sampleReq),
		.sample0(sample0),
		.sample1(sample1),
		.mix(mix)
	);

	// ----------------------------------------------------------
	// I2S output
	// ----------------------------------------------------------

	i2sTransmitter i2sInst
	(
		.iMCLK(iMCLK),
		.reset(reset),
		.mix(mix),
		.sampleReq(sampleReq),
		.i2sBclk(i2sBclk),
		.i2sLrclk(i2sLrclk),
		.i2sSdata(i2sSdata)
	);

	// Codec master clock is the system clock
	assign i2sMclk = iMCLK;

endmodule

//--- dv/tbClockGen.sv
`timescale 1ns/100ps

module tbClockGen
(
	output logic iMCLK,
	output logic reset
);

	// 10 ns period
	initial
	begin
		iMCLK = 1'b0;
		forever
			#5 iMCLK = ~iMCLK;
	end

	// Reset held over three rising edges, released on a falling edge
	initial
	begin
		reset = 1'b1;
		repeat (3) @(posedge iMCLK);
		@(negedge iMCLK);
		reset = 1'b0;
	end

endmodule

//--- dv/synth_properties.sv
`timescale 1ns/100ps

module synthProperties
#(
	parameter bit IsTransmitter = 1'b0
)
(
	input logic iMCLK,
	input logic reset,
	input logic strobe,
	input logic bclk,
	input logic lrclk
);

	// Byte valid and sample request are both one-cycle strobes
	strobeOneCycle: assert property (@(posedge iMCLK) disable iff (reset) strobe |=> !strobe)
		else $error("Strobe stayed high for more than one cycle");

	// ------------------------------------------------------------
	// I2S framing
	// ------------------------------------------------------------

	if (IsTransmitter)
	begin : txChecks
		logic [8:0] gapCnt;
		logic       primed;

		// Cycles since the last frame strobe
		always_ff @(posedge iMCLK)
		begin
			if (reset)
			begin
				gapCnt <= '0;
				primed <= 1'b0;
			end
			else if (strobe)
			begin
				gapCnt <= '0;
				primed <= 1'b1;
			end
			else
				gapCnt <= gapCnt + 9'd1;
		end

		lrOnFallingBclk: assert property (@(posedge iMCLK) disable iff (reset)
			$changed(lrclk) |-> $fell(bclk))
			else $error("LRCLK moved away from a falling BCLK edge");

		// First strobe after reset has no earlier one to measure from
		framePeriod: assert property (@(posedge iMCLK) disable iff (reset)
			strobe && primed |-> (gapCnt == 9'd255))
			else $error("Sample request spacing is not 256 cycles");
	end

endmodule

bind midiByteRx synthProperties #(.IsTransmitter(1'b0)) rxProps
(
	.iMCLK(iMCLK),
	.reset(reset),
	.strobe(byteValid),
	.bclk(1'b0),
	.lrclk(1'b0)
);

bind i2sTransmitter synthProperties #(.IsTransmitter(1'b1)) txProps
(
	.iMCLK(iMCLK),
	.reset(reset),
	.strobe(sampleReq),
	.bclk(i2sBclk),
	.lrclk(i2sLrclk)
);

//--- dv/synthTb.sv
`timescale 1ns/100ps
`include "synth_settings.svh"

module synthTb;

	// ------------------------------------------------------------
	// Test lengths in frames
	// ------------------------------------------------------------

	localparam int IdleFrames   = 12;
	localparam int ToneFrames   = 40;
	localparam int SettleFrames = 4;
	localparam int QuietFrames  = 8;
	// Two full periods of the slower voice, key 116
	localparam int ComboFrames  = 48;
	localparam int MidiBytes    = 26;
	localparam int ByteFrames   = (MidiBytes * 10 * `SYNTH_CLKS_PER_BIT + 255) / 256;
	localparam int TotalFrames  = IdleFrames + 2 * ToneFrames + 4 * SettleFrames
		+ 3 * QuietFrames + ComboFrames + ByteFrames;
	localparam int WatchdogNs   = (TotalFrames + 20) * 256 * 10;

	// Compare modes
	localparam int ModeIgnore = 0;
	localparam int ModeSilent = 1;
	localparam int ModeAlign  = 2;
	localparam int ModeCombo  = 3;

	logic        iMCLK;
	logic        reset;
	logic        midiIn;
	logic        i2sMclk;
	logic        i2sBclk;
	logic        i2sLrclk;
	logic        i2sSdata;

	// Expectation state, written by the stimulus
	int          mode;
	string       testName;
	logic [6:0]  tone0Key;
	logic [6:0]  tone0Vel;
	logic [6:0]  tone0Vol;
	logic [6:0]  tone1Key;
	logic [6:0]  tone1Vel;
	logic [6:0]  tone1Vol;

	// Compare state
	int          valueErrors;
	int          otherErrors;
	int          framesSeen;
	logic        aligned;
	int          toneIdx;
	logic [3:0]  seen;
	logic [31:0] lfsrState;

	// Capture state, left word in the upper half
	logic [31:0] frameQ [$];
	logic        bclkPrev;
	logic        lrPrev;
	int          slotBit;
	logic [15:0] slotWord;
	logic [15:0] leftWord;
	logic        haveLeft;

	tbClockGen clockGen
	(
		.iMCLK(iMCLK),
		.reset(reset)
	);

	synthTop synthTop_i
	(
		.iMCLK(iMCLK),
		.reset(reset),
		.midiIn(midiIn),
		.i2sMclk(i2sMclk),
		.i2sBclk(i2sBclk),
		.i2sLrclk(i2sLrclk),
		.i2sSdata(i2sSdata)
	);

	// ------------------------------------------------------------
	// Reference model and random source
	// ------------------------------------------------------------

	// One voice, idx counts sample requests since onset
	function automatic int refVoice(input logic gate, input logic [6:0] key,
		input logic [6:0] vel, input logic [6:0] vol, input int idx);
		int halfPeriod;
		int amp;
		halfPeriod = 128 - int'(key);
		amp = int'(vel) * int'(vol);
		if (!gate)
			return 0;
		// Positive half first
		if ((idx / halfPeriod) % 2 == 0)
			return amp;
		return -amp;
	endfunction

	// Galois LFSR, one step per bit
	function logic [31:0] randomBits(input int n);
		logic [31:0] val;
		logic        lsb;
		int          i;
		val = '0;
		for (i = 0; i < n; i++)
		begin
			lsb = lfsrState[0];
			lfsrState = lfsrState >> 1;
			if (lsb)
				lfsrState = lfsrState ^ 32'h80200003;
			val = {val[30:0], lsb};
		end
		return val;
	endfunction

	// Seven bit level, never zero
	function logic [6:0] randomLevel();
		logic [31:0] raw;
		raw = randomBits(7);
		if (raw[6:0] == 7'd0)
			return 7'd1;
		return raw[6:0];
	endfunction

	// ------------------------------------------------------------
	// MIDI driver
	// ------------------------------------------------------------

	// 8N1, LSB first, inverted line so idle is low
	task automatic sendByte(input logic [7:0] data);
		int i;
		midiIn = 1'b1;
		repeat (`SYNTH_CLKS_PER_BIT) @(negedge iMCLK);
		for (i = 0; i < 8; i++)
		begin
			midiIn = ~data[i];
			repeat (`SYNTH_CLKS_PER_BIT) @(negedge iMCLK);
		end
		midiIn = 1'b0;
		repeat (`SYNTH_CLKS_PER_BIT) @(negedge iMCLK);
	endtask

	task automatic waitFrames(input int n);
		int target;
		target = framesSeen + n;
		while (framesSeen < target)
			@(negedge iMCLK);
	endtask

	// ------------------------------------------------------------
	// I2S capture and compare
	// ------------------------------------------------------------

	// Sample on rising BCLK, bit 0 of a slot is the one-bit delay
	always @(negedge iMCLK)
	begin
		if (reset)
		begin
			bclkPrev = 1'b0;
			lrPrev   = 1'b0;
			slotBit  = 0;
			haveLeft = 1'b0;
		end
		else
		begin
			if (i2sBclk && !bclkPrev)
			begin
				if (i2sLrclk != lrPrev)
					slotBit = 0;
				else
					slotBit = slotBit + 1;
				lrPrev = i2sLrclk;
				if (slotBit >= 1 && slotBit <= 16)
					slotWord = {slotWord[14:0], i2sSdata};
				if (slotBit == 16 && !i2sLrclk)
				begin
					leftWord = slotWord;
					haveLeft = 1'b1;
				end
				else if (slotBit == 16 && haveLeft)
				begin
					frameQ.push_back({leftWord, slotWord});
					haveLeft = 1'b0;
				end
			end
			bclkPrev = i2sBclk;
		end
	end

	// Codec master clock follows iMCLK, looked at 2 ns after each edge
	always @(iMCLK)
	begin
		#2;
		if (!reset)
		begin
			assert (i2sMclk === iMCLK)
			else
			begin
				valueErrors++;
				$display("Error %s: expected i2sMclk %b, actual %b", testName, iMCLK, i2sMclk);
			end
		end
	end

	task automatic checkFrame(input synthPkg::sampleT left, input synthPkg::sampleT right);
		int   expVal;
		int   a0;
		int   a1;
		int   combo [4];
		logic matched;
		int   i;
		// Mono mix in both slots
		assert (right == left)
		else
		begin
			valueErrors++;
			$display("Error %s: expected right slot %0d, actual %0d", testName, left, right);
		end
		case (mode)
			ModeSilent:
			begin
				assert (left == 0)
				else
				begin
					valueErrors++;
					$display("Error %s: expected 0, actual %0d", testName, left);
				end
			end
			ModeAlign:
			begin
				// First nonzero frame is the onset
				if (!aligned && left != 0)
				begin
					aligned = 1'b1;
					toneIdx = 0;
				end
				if (aligned)
				begin
					expVal = refVoice(1'b1, tone0Key, tone0Vel, tone0Vol, toneIdx);
					assert (int'(left) == expVal)
					else
					begin
						valueErrors++;
						$display("Error %s: expected %0d, actual %0d", testName, expVal, left);
					end
					toneIdx++;
				end
			end
			ModeCombo:
			begin
				a0 = refVoice(1'b1, tone0Key, tone0Vel, tone0Vol, 0);
				a1 = refVoice(1'b1, tone1Key, tone1Vel, tone1Vol, 0);
				matched = 1'b0;
				for (i = 0; i < 4; i++)
				begin
					combo[i] = (i[0] ? -a0 : a0) + (i[1] ? -a1 : a1);
					if (int'(left) == combo[i])
					begin
						seen[i] = 1'b1;
						matched = 1'b1;
					end
				end
				assert (matched)
				else
				begin
					valueErrors++;
					$display("Error %s: expected one of %0d %0d %0d %0d, actual %0d", testName,
						combo[0], combo[1], combo[2], combo[3], left);
				end
			end
			default:
			begin
			end
		endcase
	endtask

	always @(posedge iMCLK)
	begin
		while (frameQ.size() > 0)
		begin
			checkFrame(frameQ[0][31:16], frameQ[0][15:0]);
			void'(frameQ.pop_front());
			framesSeen++;
		end
	end

	// ------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------

	initial
	begin : stimulus
		logic [6:0] newVol;
		midiIn      = 1'b0;
		mode        = ModeSilent;
		testName    = "idle";
		valueErrors = 0;
		otherErrors = 0;
		framesSeen  = 0;
		aligned     = 1'b0;
		toneIdx     = 0;
		seen        = 4'b0000;
		lfsrState   = 32'hf913;
		tone0Key    = 7'd120;
		tone0Vel    = 7'd0;
		tone0Vol    = 7'(`SYNTH_DEFAULT_VOLUME);
		tone1Key    = 7'd116;
		tone1Vel    = 7'd0;
		tone1Vol    = 7'(`SYNTH_DEFAULT_VOLUME);
		@(negedge iMCLK);
		wait (!reset);
		waitFrames(IdleFrames);

		// Voice 0 at default volume
		testName = "noteOn";
		tone0Vel = randomLevel();
		aligned  = 1'b0;
		mode     = ModeAlign;
		sendByte(8'h90);
		sendByte({1'b0, tone0Key});
		sendByte({1'b0, tone0Vel});
		waitFrames(ToneFrames);
		assert (aligned)
		else
		begin
			otherErrors++;
			$display("Voice 0 tone never started in %s", testName);
		end

		// Held note keeps its amplitude through the volume change
		testName = "volume";
		newVol   = randomLevel();
		sendByte(8'hB0);
		sendByte(8'h07);
		sendByte({1'b0, newVol});
		waitFrames(SettleFrames);

		testName = "noteOff";
		mode     = ModeIgnore;
		sendByte(8'h80);
		sendByte({1'b0, tone0Key});
		sendByte(8'h40);
		waitFrames(SettleFrames);
		mode = ModeSilent;
		waitFrames(QuietFrames);

		// Next onset picks up the new volume
		testName = "volume";
		tone0Vol = newVol;
		aligned  = 1'b0;
		mode     = ModeAlign;
		sendByte(8'h90);
		sendByte({1'b0, tone0Key});
		sendByte({1'b0, tone0Vel});
		waitFrames(ToneFrames);
		assert (aligned)
		else
		begin
			otherErrors++;
			$display("Voice 0 tone never restarted after the volume change");
		end

		// Velocity zero with no status byte
		testName = "runStatus";
		mode     = ModeIgnore;
		sendByte({1'b0, tone0Key});
		sendByte(8'h00);
		waitFrames(SettleFrames);
		mode = ModeSilent;
		waitFrames(QuietFrames);

		// Channel 2 drives neither voice
		testName = "otherChannel";
		sendByte(8'h92);
		sendByte(8'h64);
		sendByte(8'h50);
		sendByte(8'hB2);
		sendByte(8'h07);
		sendByte(8'h05);
		waitFrames(QuietFrames);

		testName = "twoVoices";
		tone0Vel = randomLevel();
		tone1Vel = randomLevel();
		mode     = ModeIgnore;
		sendByte(8'h90);
		sendByte({1'b0, tone0Key});
		sendByte({1'b0, tone0Vel});
		sendByte(8'h91);
		sendByte({1'b0, tone1Key});
		sendByte({1'b0, tone1Vel});
		waitFrames(SettleFrames);
		seen = 4'b0000;
		mode = ModeCombo;
		waitFrames(ComboFrames);
		assert (seen == 4'b1111)
		else
		begin
			otherErrors++;
			$display("Not every sign combination of the two voices showed up, seen %b", seen);
		end

		$display("Value errors: %0d, other errors: %0d", valueErrors, otherErrors);
		if (valueErrors + otherErrors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	// ------------------------------------------------------------
	// Watchdog
	// ------------------------------------------------------------

	initial
	begin
		#(WatchdogNs);
		$display("Timeout after %0d ns, the tests did not reach their end", WatchdogNs);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

//--- sim.f
+incdir+design
design/synthPkg.sv
design/midiByteRx.sv
design/midiDecoder.sv
design/toneVoice.sv
design/voiceMixer.sv
design/i2sTransmitter.sv
design/synthTop.sv
dv/tbClockGen.sv
dv/synth_properties.sv
dv/synthTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the synth testbench with Verilator and run it
# Pass or fail is read from the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module synthTb \
	-Mdir obj_dir -o synthSim > build.log 2>&1 \
	&& ./obj_dir/synthSim > sim.log 2>&1 \
	|| echo "Build or run ended with an error"

cat sim.log 2>/dev/null

grep -q "ALL CHECKS PASSED" sim.log 2>/dev/null \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed, see build.log and sim.log"; exit 1; }
